// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  localparam int data_w = 32;
  localparam int reg_addr_w = 5;

  // host address map
  localparam logic [31:0] issue_addr = 32'h0000_0100;
  localparam logic [31:0] status_addr = 32'h0000_0080;

  // instruction field positions
  localparam int op_lsb = 26;
  localparam int op_w = 6;
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;
  localparam int shamt_lsb = 6;
  localparam int funct_lsb = 0;
  localparam int funct_w = 6;
  localparam int imm_lsb = 0;
  localparam int imm_w = 16;

  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f
  } opcode_e;

  // SPECIAL function codes
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_sra  = 6'h03,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/axi_issue_port.sv
`timescale 1ns/10ps
`default_nettype none

module axi_issue_port #(
  parameter int addr_w = 12
) (
  input  wire                clk,
  input  wire                rst_n,
  // write address and data
  input  wire                awvalid,
  input  wire [addr_w-1:0]   awaddr,
  output logic               awready,
  input  wire                wvalid,
  input  wire [31:0]         wdata,
  input  wire [3:0]          wstrb,
  output logic               wready,
  // write response
  output logic               bvalid,
  output logic [1:0]         bresp,
  input  wire                bready,
  // read address and data
  input  wire                arvalid,
  input  wire [addr_w-1:0]   araddr,
  output logic               arready,
  output logic               rvalid,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  input  wire                rready,
  // pipeline side
  input  wire                busy,
  output logic               issue_valid,
  output logic [31:0]        issue_inst,
  output logic [4:0]         host_rd_addr,
  input  wire [31:0]         host_rd_data,
  input  wire [31:0]         exc_count
);

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic wr_rdy;
  logic rd_rdy;
  logic wr_take;
  logic rd_take;
  logic bvalid_nxt;
  logic rvalid_nxt;
  logic is_issue;
  logic is_reg;
  logic is_status;

  // both channels must be valid together before the handshake completes
  assign wr_take = wr_rdy & awvalid & wvalid;
  assign awready = wr_take;
  assign wready = wr_take;

  assign arready = rd_rdy;
  assign rd_take = rd_rdy & arvalid;

  assign is_issue = (awaddr == addr_w'(mips_pkg::issue_addr));
  assign issue_valid = wr_take & is_issue;

  // unstrobed bytes read as zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      issue_inst[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : 8'h00;
    end
  end

  assign host_rd_addr = araddr[6:2];
  assign is_reg = ((araddr >> 7) == '0);
  assign is_status = (araddr == addr_w'(mips_pkg::status_addr));

  assign bvalid_nxt = wr_take | (bvalid & ~bready);
  assign rvalid_nxt = rd_take | (rvalid & ~rready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_rdy <= 1'b0;
      rd_rdy <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      wr_rdy <= ~bvalid_nxt;
      // reads wait until every issued instruction has retired
      rd_rdy <= ~busy & ~bvalid_nxt & ~rvalid_nxt;
      bvalid <= bvalid_nxt;
      rvalid <= rvalid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_take) begin
      bresp <= is_issue ? resp_okay : resp_slverr;
    end
    if (rd_take) begin
      if (is_reg) begin
        rdata <= host_rd_data;
        rresp <= resp_okay;
      end else if (is_status) begin
        rdata <= exc_count;
        rresp <= resp_okay;
      end else begin
        rdata <= '0;
        rresp <= resp_slverr;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
  input  wire                          clk,
  input  wire                          rst_n,
  // issued instruction
  input  wire                          issue_valid,
  input  wire [mips_pkg::data_w-1:0]   issue_inst,
  // register file read ports
  output logic [mips_pkg::reg_addr_w-1:0] rd_addr_1,
  output logic [mips_pkg::reg_addr_w-1:0] rd_addr_2,
  input  wire [mips_pkg::data_w-1:0]   rd_data_1,
  input  wire [mips_pkg::data_w-1:0]   rd_data_2,
  // forward path from execute
  input  wire                          fwd_write_en,
  input  wire [mips_pkg::reg_addr_w-1:0] fwd_addr,
  input  wire [mips_pkg::data_w-1:0]   fwd_data,
  // to execute
  output logic                         dec_valid,
  output logic                         ex_valid,
  output mips_pkg::alu_op_e            ex_alu_op,
  output logic [mips_pkg::data_w-1:0]  ex_operand_1,
  output logic [mips_pkg::data_w-1:0]  ex_operand_2,
  output logic [4:0]                   ex_shamt,
  output logic                         ex_write_en,
  output logic [mips_pkg::reg_addr_w-1:0] ex_write_addr,
  output logic                         ex_exception
);

  logic [mips_pkg::data_w-1:0] dec_inst;
  mips_pkg::opcode_e opcode;
  mips_pkg::funct_e funct;
  logic [mips_pkg::reg_addr_w-1:0] rs;
  logic [mips_pkg::reg_addr_w-1:0] rt;
  logic [mips_pkg::reg_addr_w-1:0] rd;
  logic [4:0] shamt;
  logic [mips_pkg::imm_w-1:0] imm;
  logic [mips_pkg::data_w-1:0] imm_sext;
  logic [mips_pkg::data_w-1:0] imm_zext;
  logic [mips_pkg::data_w-1:0] src_1;
  logic [mips_pkg::data_w-1:0] src_2;
  mips_pkg::alu_op_e alu_op;
  logic [mips_pkg::data_w-1:0] operand_2;
  logic write_en;
  logic exception;
  logic [mips_pkg::reg_addr_w-1:0] write_addr;

  // execute result wins over the register file on a nonzero match
  function automatic logic [mips_pkg::data_w-1:0] pick_operand(
    input logic [mips_pkg::reg_addr_w-1:0] addr,
    input logic [mips_pkg::data_w-1:0]     rf_data
  );
    if (fwd_write_en && fwd_addr != '0 && fwd_addr == addr) begin
      return fwd_data;
    end
    return rf_data;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      dec_inst <= issue_inst;
    end
  end

  // field split
  assign opcode = mips_pkg::opcode_e'(dec_inst[mips_pkg::op_lsb +: mips_pkg::op_w]);
  assign funct = mips_pkg::funct_e'(dec_inst[mips_pkg::funct_lsb +: mips_pkg::funct_w]);
  assign rs = dec_inst[mips_pkg::rs_lsb +: mips_pkg::reg_addr_w];
  assign rt = dec_inst[mips_pkg::rt_lsb +: mips_pkg::reg_addr_w];
  assign rd = dec_inst[mips_pkg::rd_lsb +: mips_pkg::reg_addr_w];
  assign shamt = dec_inst[mips_pkg::shamt_lsb +: 5];
  assign imm = dec_inst[mips_pkg::imm_lsb +: mips_pkg::imm_w];
  assign imm_sext = {{16{imm[15]}}, imm};
  assign imm_zext = {16'h0000, imm};

  assign rd_addr_1 = rs;
  assign rd_addr_2 = rt;
  assign src_1 = pick_operand(rs, rd_data_1);
  assign src_2 = pick_operand(rt, rd_data_2);

  always_comb begin
    alu_op = mips_pkg::alu_add;
    operand_2 = src_2;
    write_en = 1'b1;
    write_addr = rt;
    exception = 1'b0;
    case (opcode)
      mips_pkg::op_special: begin
        write_addr = rd;
        case (funct)
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
          mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
          mips_pkg::fn_sra:  alu_op = mips_pkg::alu_sra;
          default: begin
            write_en = 1'b0;
            exception = 1'b1;
          end
        endcase
      end
      mips_pkg::op_addiu: operand_2 = imm_sext;
      mips_pkg::op_slti: begin
        alu_op = mips_pkg::alu_slt;
        operand_2 = imm_sext;
      end
      // logical immediates are zero extended
      mips_pkg::op_andi: begin
        alu_op = mips_pkg::alu_and;
        operand_2 = imm_zext;
      end
      mips_pkg::op_ori: begin
        alu_op = mips_pkg::alu_or;
        operand_2 = imm_zext;
      end
      mips_pkg::op_xori: begin
        alu_op = mips_pkg::alu_xor;
        operand_2 = imm_zext;
      end
      mips_pkg::op_lui: begin
        alu_op = mips_pkg::alu_lui;
        operand_2 = imm_zext;
      end
      default: begin
        write_en = 1'b0;
        exception = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_write_en <= 1'b0;
      ex_exception <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
      ex_write_en <= dec_valid & write_en;
      ex_exception <= dec_valid & exception;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op <= alu_op;
    ex_operand_1 <= src_1;
    ex_operand_2 <= operand_2;
    ex_shamt <= shamt;
    ex_write_addr <= write_addr;
  end

endmodule

`default_nettype wire

// File: rtl/alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
  input  wire                             clk,
  input  wire                             rst_n,
  // from decode
  input  wire                             ex_valid,
  input  var mips_pkg::alu_op_e           ex_alu_op,
  input  wire [mips_pkg::data_w-1:0]      ex_operand_1,
  input  wire [mips_pkg::data_w-1:0]      ex_operand_2,
  input  wire [4:0]                       ex_shamt,
  input  wire                             ex_write_en,
  input  wire [mips_pkg::reg_addr_w-1:0]  ex_write_addr,
  input  wire                             ex_exception,
  // forward path back to decode
  output logic                            fwd_write_en,
  output logic [mips_pkg::reg_addr_w-1:0] fwd_addr,
  output logic [mips_pkg::data_w-1:0]     fwd_data,
  // writeback stage
  output logic                            wb_valid,
  output logic                            wb_write_en,
  output logic [mips_pkg::reg_addr_w-1:0] wb_write_addr,
  output logic [mips_pkg::data_w-1:0]     wb_data,
  output logic                            wb_exception
);

  logic [mips_pkg::data_w-1:0] result;

  always_comb begin
    case (ex_alu_op)
      mips_pkg::alu_add:  result = ex_operand_1 + ex_operand_2;
      mips_pkg::alu_sub:  result = ex_operand_1 - ex_operand_2;
      mips_pkg::alu_and:  result = ex_operand_1 & ex_operand_2;
      mips_pkg::alu_or:   result = ex_operand_1 | ex_operand_2;
      mips_pkg::alu_xor:  result = ex_operand_1 ^ ex_operand_2;
      mips_pkg::alu_nor:  result = ~(ex_operand_1 | ex_operand_2);
      mips_pkg::alu_slt:  result = {31'b0, $signed(ex_operand_1) < $signed(ex_operand_2)};
      mips_pkg::alu_sltu: result = {31'b0, ex_operand_1 < ex_operand_2};
      // shifts act on the rt operand
      mips_pkg::alu_sll:  result = ex_operand_2 << ex_shamt;
      mips_pkg::alu_srl:  result = ex_operand_2 >> ex_shamt;
      mips_pkg::alu_sra:  result = $unsigned($signed(ex_operand_2) >>> ex_shamt);
      mips_pkg::alu_lui:  result = {ex_operand_2[15:0], 16'h0000};
      default:            result = '0;
    endcase
  end

  assign fwd_write_en = ex_valid & ex_write_en;
  assign fwd_addr = ex_write_addr;
  assign fwd_data = result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_write_en <= 1'b0;
      wb_exception <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
      wb_write_en <= ex_valid & ex_write_en;
      wb_exception <= ex_valid & ex_exception;
    end
  end

  always_ff @(posedge clk) begin
    wb_write_addr <= ex_write_addr;
    wb_data <= result;
  end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                             clk,
  input  wire                             rst_n,
  // writeback
  input  wire                             wb_valid,
  input  wire                             wb_write_en,
  input  wire [mips_pkg::reg_addr_w-1:0]  wb_write_addr,
  input  wire [mips_pkg::data_w-1:0]      wb_data,
  input  wire                             wb_exception,
  // decode read ports
  input  wire [mips_pkg::reg_addr_w-1:0]  rd_addr_1,
  input  wire [mips_pkg::reg_addr_w-1:0]  rd_addr_2,
  output logic [mips_pkg::data_w-1:0]     rd_data_1,
  output logic [mips_pkg::data_w-1:0]     rd_data_2,
  // host side
  input  wire [mips_pkg::reg_addr_w-1:0]  host_rd_addr,
  output logic [mips_pkg::data_w-1:0]     host_rd_data,
  output logic [31:0]                     exc_count
);

  logic [mips_pkg::data_w-1:0] regs [32];
  logic wr_fire;

  // r0 never takes a write
  assign wr_fire = wb_valid & wb_write_en & (wb_write_addr != '0);

  // same-cycle write passes straight through
  function automatic logic [mips_pkg::data_w-1:0] read_port(
    input logic [mips_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (wr_fire && wb_write_addr == addr) begin
      return wb_data;
    end
    return regs[addr];
  endfunction

  assign rd_data_1 = read_port(rd_addr_1);
  assign rd_data_2 = read_port(rd_addr_2);
  assign host_rd_data = read_port(host_rd_addr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      exc_count <= '0;
    end else begin
      if (wr_fire) begin
        regs[wb_write_addr] <= wb_data;
      end
      if (wb_valid && wb_exception) begin
        exc_count <= exc_count + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_core_top #(
  parameter int addr_w = 12
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               awvalid,
  input  wire [addr_w-1:0]  awaddr,
  output logic              awready,
  input  wire               wvalid,
  input  wire [31:0]        wdata,
  input  wire [3:0]         wstrb,
  output logic              wready,
  output logic              bvalid,
  output logic [1:0]        bresp,
  input  wire               bready,
  input  wire               arvalid,
  input  wire [addr_w-1:0]  araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  input  wire               rready
);

  logic        busy;
  logic        issue_valid;
  logic [31:0] issue_inst;
  logic [4:0]  host_rd_addr;
  logic [31:0] host_rd_data;
  logic [31:0] exc_count;
  logic [4:0]  rd_addr_1;
  logic [4:0]  rd_addr_2;
  logic [31:0] rd_data_1;
  logic [31:0] rd_data_2;
  logic        fwd_write_en;
  logic [4:0]  fwd_addr;
  logic [31:0] fwd_data;
  logic        dec_valid;
  logic        ex_valid;
  mips_pkg::alu_op_e ex_alu_op;
  logic [31:0] ex_operand_1;
  logic [31:0] ex_operand_2;
  logic [4:0]  ex_shamt;
  logic        ex_write_en;
  logic [4:0]  ex_write_addr;
  logic        ex_exception;
  logic        wb_valid;
  logic        wb_write_en;
  logic [4:0]  wb_write_addr;
  logic [31:0] wb_data;
  logic        wb_exception;

  // any instruction still in flight
  assign busy = dec_valid | ex_valid | wb_valid;

  axi_issue_port #(.addr_w(addr_w)) u_port (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
    .busy(busy), .issue_valid(issue_valid), .issue_inst(issue_inst),
    .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data), .exc_count(exc_count)
  );

  inst_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .issue_valid(issue_valid), .issue_inst(issue_inst),
    .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
    .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
    .fwd_write_en(fwd_write_en), .fwd_addr(fwd_addr), .fwd_data(fwd_data),
    .dec_valid(dec_valid), .ex_valid(ex_valid), .ex_alu_op(ex_alu_op),
    .ex_operand_1(ex_operand_1), .ex_operand_2(ex_operand_2), .ex_shamt(ex_shamt),
    .ex_write_en(ex_write_en), .ex_write_addr(ex_write_addr), .ex_exception(ex_exception)
  );

  alu_exec u_exec (
    .clk(clk), .rst_n(rst_n),
    .ex_valid(ex_valid), .ex_alu_op(ex_alu_op),
    .ex_operand_1(ex_operand_1), .ex_operand_2(ex_operand_2), .ex_shamt(ex_shamt),
    .ex_write_en(ex_write_en), .ex_write_addr(ex_write_addr), .ex_exception(ex_exception),
    .fwd_write_en(fwd_write_en), .fwd_addr(fwd_addr), .fwd_data(fwd_data),
    .wb_valid(wb_valid), .wb_write_en(wb_write_en), .wb_write_addr(wb_write_addr),
    .wb_data(wb_data), .wb_exception(wb_exception)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .wb_valid(wb_valid), .wb_write_en(wb_write_en), .wb_write_addr(wb_write_addr),
    .wb_data(wb_data), .wb_exception(wb_exception),
    .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
    .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
    .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data), .exc_count(exc_count)
  );

endmodule

`default_nettype wire

// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state as the host should see it
logic [31:0] model_regs [32];
int model_exc;

function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
  input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
  return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
  input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  model_exc = 0;
endfunction

// returns 0 for a reserved encoding
function automatic bit model_eval(input logic [31:0] inst, output logic [4:0] dest,
  output logic [31:0] val);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] sext;
  logic [31:0] zext;
  logic [4:0] sh;
  a = model_regs[inst[25:21]];
  b = model_regs[inst[20:16]];
  sext = {{16{inst[15]}}, inst[15:0]};
  zext = {16'h0000, inst[15:0]};
  sh = inst[10:6];
  dest = inst[20:16];
  val = '0;
  case (inst[31:26])
    mips_pkg::op_special: begin
      dest = inst[15:11];
      case (inst[5:0])
        mips_pkg::fn_addu: val = a + b;
        mips_pkg::fn_subu: val = a - b;
        mips_pkg::fn_and:  val = a & b;
        mips_pkg::fn_or:   val = a | b;
        mips_pkg::fn_xor:  val = a ^ b;
        mips_pkg::fn_nor:  val = ~(a | b);
        mips_pkg::fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        mips_pkg::fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
        mips_pkg::fn_sll:  val = b << sh;
        mips_pkg::fn_srl:  val = b >> sh;
        mips_pkg::fn_sra:  val = $signed(b) >>> sh;
        default: return 1'b0;
      endcase
    end
    mips_pkg::op_addiu: val = a + sext;
    mips_pkg::op_slti:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
    mips_pkg::op_andi:  val = a & zext;
    mips_pkg::op_ori:   val = a | zext;
    mips_pkg::op_xori:  val = a ^ zext;
    mips_pkg::op_lui:   val = {inst[15:0], 16'h0000};
    default: return 1'b0;
  endcase
  return 1'b1;
endfunction

function automatic void model_apply(input logic [31:0] inst);
  logic [4:0] dest;
  logic [31:0] val;
  if (!model_eval(inst, dest, val)) begin
    model_exc++;
  end else if (dest != 5'd0) begin
    model_regs[dest] = val;
  end
endfunction

`endif

// File: bench/tb_decode_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_core;

  localparam int n_rtype = 200;
  localparam int batch = 20;
  localparam int n_imm = 100;
  localparam int n_chain = 4;
  localparam int chain_len = 16;
  localparam int n_rsvd = 40;
  localparam int n_r0 = 8;
  localparam int n_bad_wr = 10;
  localparam int n_bad_rd = 10;
  localparam int n_stall = 4;
  // a register sweep is 32 reads
  localparam int planned_xfers = n_rtype + (n_rtype / batch) * 32 + n_imm
    + (n_imm / batch) * 32 + n_chain * (chain_len + 32) + n_rsvd + n_r0 + 33
    + n_bad_wr + 32 + n_bad_rd + 2 * n_stall + 32;
  localparam int cycle_limit = 40 * planned_xfers;
  localparam logic [11:0] issue_at = 12'(mips_pkg::issue_addr);
  localparam logic [11:0] status_at = 12'(mips_pkg::status_addr);
  localparam logic [5:0] funct_tab [11] = '{mips_pkg::fn_sll, mips_pkg::fn_srl,
    mips_pkg::fn_sra, mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and,
    mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt, mips_pkg::fn_sltu};
  localparam logic [5:0] op_tab [6] = '{mips_pkg::op_addiu, mips_pkg::op_slti,
    mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};

  logic clk;
  logic rst_n;
  logic awvalid;
  logic [11:0] awaddr;
  logic wvalid;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic bready;
  logic arvalid;
  logic [11:0] araddr;
  logic rready;
  wire awready;
  wire wready;
  wire bvalid;
  wire [1:0] bresp;
  wire arready;
  wire rvalid;
  wire [31:0] rdata;
  wire [1:0] rresp;

  logic [15:0] lfsr;
  int err_count;
  int check_count;
  int cycles;

  `include "tb_ref_model.svh"

  decode_core_top #(.addr_w(12)) dut (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run did not finish within the limit of %0d cycles", cycle_limit);
      $display("%0d checks, %0d errors", check_count, err_count);
      $display("Checks failed");
      $finish;
    end
  end

  // galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] rtype_inst(input logic [4:0] rs, input logic [4:0] rt,
    input logic [4:0] rd);
    int sel;
    logic [4:0] shamt;
    sel = rand_bits(4) % 11;
    shamt = rand_bits(5);
    return enc_r(funct_tab[sel], rs, rt, rd, shamt);
  endfunction

  function automatic logic [31:0] itype_inst(input logic [4:0] rs, input logic [4:0] rt);
    int sel;
    logic [15:0] imm;
    sel = rand_bits(3) % 6;
    imm = rand_bits(16);
    return enc_i(op_tab[sel], rs, rt, imm);
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
    input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic await_write_accept();
    bit done;
    done = 0;
    for (int w = 0; w < 50 && !done; w++) begin
      @(posedge clk);
      done = awready && wready;
    end
    if (!done) begin
      $display("write to %h was not accepted within 50 cycles", awaddr);
      err_count++;
    end
  endtask

  task automatic await_write_resp(output logic [1:0] resp);
    bit done;
    done = 0;
    for (int w = 0; w < 50 && !done; w++) begin
      @(posedge clk);
      done = bvalid && bready;
      resp = bresp;
    end
    if (!done) begin
      $display("no write response arrived within 50 cycles");
      err_count++;
    end
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
    output logic [1:0] resp);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    await_write_accept();
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    await_write_resp(resp);
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
    output logic [1:0] resp);
    bit done;
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    done = 0;
    // held off while instructions are still in flight
    for (int w = 0; w < 50 && !done; w++) begin
      @(posedge clk);
      done = arready;
    end
    if (!done) begin
      $display("read of %h was not accepted within 50 cycles", addr);
      err_count++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    done = 0;
    for (int w = 0; w < 50 && !done; w++) begin
      @(posedge clk);
      done = rvalid && rready;
      data = rdata;
      resp = rresp;
    end
    if (!done) begin
      $display("no read data arrived within 50 cycles");
      err_count++;
    end
  endtask

  task automatic issue(input logic [31:0] inst);
    logic [1:0] resp;
    axi_write(issue_at, inst, resp);
    check("issue bresp", 32'd0, resp);
    model_apply(inst);
  endtask

  task automatic verify_regs(input string name);
    logic [31:0] data;
    logic [1:0] resp;
    for (int i = 0; i < 32; i++) begin
      axi_read(12'(i * 4), data, resp);
      check($sformatf("%s rresp r%0d", name, i), 32'd0, resp);
      check($sformatf("%s r%0d", name, i), model_regs[i], data);
    end
  endtask

  // first write's response held back while a second write waits
  task automatic stalled_response(input int hold, input logic [31:0] first,
    input logic [31:0] second);
    logic [1:0] resp;
    @(negedge clk);
    bready = 1'b0;
    awaddr = issue_at;
    wdata = first;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    await_write_accept();
    @(negedge clk);
    wdata = second;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      check("stall bvalid", 32'd1, bvalid);
      check("stall awready", 32'd0, awready);
      check("stall wready", 32'd0, wready);
    end
    check("stall bresp", 32'd0, bresp);
    @(negedge clk);
    bready = 1'b1;
    await_write_accept();
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    await_write_resp(resp);
    check("stall second bresp", 32'd0, resp);
    model_apply(first);
    model_apply(second);
  endtask

  initial begin
    logic [31:0] inst;
    logic [31:0] data;
    logic [1:0] resp;
    logic [11:0] addr;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] prev;
    lfsr = 16'd62021;
    err_count = 0;
    check_count = 0;
    cycles = 0;
    clk = 1'b0;
    rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = 4'h0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    model_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int n = 0; n < n_rtype; n++) begin
      rs = rand_bits(5);
      rt = rand_bits(5);
      rd = rand_bits(5);
      issue(rtype_inst(rs, rt, rd));
      if (n % batch == batch - 1) begin
        verify_regs("rtype");
      end
    end

    for (int n = 0; n < n_imm; n++) begin
      rs = rand_bits(5);
      rt = rand_bits(5);
      issue(itype_inst(rs, rt));
      if (n % batch == batch - 1) begin
        verify_regs("immediate");
      end
    end

    // each source is the previous destination
    for (int c = 0; c < n_chain; c++) begin
      prev = rand_bits(5);
      for (int n = 0; n < chain_len; n++) begin
        rd = rand_bits(5);
        if (rd == 5'd0) begin
          rd = 5'd1;
        end
        if (rand_bits(1)) begin
          inst = rtype_inst(prev, prev, rd);
        end else begin
          inst = itype_inst(prev, rd);
        end
        issue(inst);
        prev = rd;
      end
      verify_regs("chain");
    end

    for (int n = 0; n < n_rsvd; n++) begin
      inst = rand_bits(32);
      while (model_eval(inst, rd, data)) begin
        inst = rand_bits(32);
      end
      issue(inst);
    end
    // count read right behind the last reserved instruction
    axi_read(status_at, data, resp);
    check("exception count", model_exc, data);
    for (int n = 0; n < n_r0; n++) begin
      rs = rand_bits(5);
      rt = rand_bits(5);
      if (n % 2) begin
        inst = rtype_inst(rs, rt, 5'd0);
      end else begin
        inst = itype_inst(rs, 5'd0);
      end
      issue(inst);
    end
    verify_regs("reserved");

    for (int n = 0; n < n_bad_wr; n++) begin
      addr = 12'(rand_bits(10) << 2);
      if (addr == issue_at) begin
        addr = 12'h104;
      end
      rs = rand_bits(5);
      rt = rand_bits(5);
      rd = rand_bits(5);
      axi_write(addr, rtype_inst(rs, rt, rd), resp);
      check("bad write bresp", 32'd2, resp);
    end
    verify_regs("bad write");

    for (int n = 0; n < n_bad_rd; n++) begin
      addr = 12'(rand_bits(10) << 2);
      if (addr <= status_at) begin
        addr = addr + 12'h100;
      end
      axi_read(addr, data, resp);
      check("bad read rresp", 32'd2, resp);
      check("bad read data", 32'd0, data);
    end

    for (int n = 0; n < n_stall; n++) begin
      rs = rand_bits(5);
      rt = rand_bits(5);
      inst = itype_inst(rs, rt);
      rs = rand_bits(5);
      rt = rand_bits(5);
      stalled_response(1 + rand_bits(3), inst, itype_inst(rs, rt));
    end
    verify_regs("back-pressure");

    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
rtl/mips_pkg.sv
rtl/axi_issue_port.sv
rtl/inst_decode.sv
rtl/alu_exec.sv
rtl/reg_file.sv
rtl/decode_core_top.sv
bench/tb_decode_core.sv
